/* common/decode_pkg.sv */
package decode_pkg;

	localparam int XLEN       = 32;
	localparam int REG_ADDR_W = 5;
	localparam int NUM_REGS   = 32;

	typedef logic [XLEN-1:0]       word_t;
	typedef logic [REG_ADDR_W-1:0] reg_addr_t;

	// linking branches and jumps write here
	localparam reg_addr_t LINK_REG = 5'd31;

	////////////////////////////////////////////////////////////////////////////
	// primary opcodes, inst[31:26]
	localparam logic [5:0] OP_SPECIAL = 6'b000000;
	localparam logic [5:0] OP_REGIMM  = 6'b000001;
	localparam logic [5:0] OP_J       = 6'b000010;
	localparam logic [5:0] OP_JAL     = 6'b000011;
	localparam logic [5:0] OP_BEQ     = 6'b000100;
	localparam logic [5:0] OP_BNE     = 6'b000101;
	localparam logic [5:0] OP_BLEZ    = 6'b000110;
	localparam logic [5:0] OP_BGTZ    = 6'b000111;
	localparam logic [5:0] OP_ADDI    = 6'b001000;
	localparam logic [5:0] OP_ADDIU   = 6'b001001;
	localparam logic [5:0] OP_SLTI    = 6'b001010;
	localparam logic [5:0] OP_SLTIU   = 6'b001011;
	localparam logic [5:0] OP_ANDI    = 6'b001100;
	localparam logic [5:0] OP_ORI     = 6'b001101;
	localparam logic [5:0] OP_XORI    = 6'b001110;
	localparam logic [5:0] OP_LUI     = 6'b001111;
	localparam logic [5:0] OP_LB      = 6'b100000;
	localparam logic [5:0] OP_LH      = 6'b100001;
	localparam logic [5:0] OP_LWL     = 6'b100010;
	localparam logic [5:0] OP_LW      = 6'b100011;
	localparam logic [5:0] OP_LBU     = 6'b100100;
	localparam logic [5:0] OP_LHU     = 6'b100101;
	localparam logic [5:0] OP_LWR     = 6'b100110;
	localparam logic [5:0] OP_SB      = 6'b101000;
	localparam logic [5:0] OP_SH      = 6'b101001;
	localparam logic [5:0] OP_SWL     = 6'b101010;
	localparam logic [5:0] OP_SW      = 6'b101011;
	localparam logic [5:0] OP_SWR     = 6'b101110;

	////////////////////////////////////////////////////////////////////////////
	// SPECIAL function codes, inst[5:0]
	localparam logic [5:0] FN_SLL  = 6'b000000;
	localparam logic [5:0] FN_SRL  = 6'b000010;
	localparam logic [5:0] FN_SRA  = 6'b000011;
	localparam logic [5:0] FN_SLLV = 6'b000100;
	localparam logic [5:0] FN_SRLV = 6'b000110;
	localparam logic [5:0] FN_SRAV = 6'b000111;
	localparam logic [5:0] FN_JR   = 6'b001000;
	localparam logic [5:0] FN_JALR = 6'b001001;
	localparam logic [5:0] FN_ADD  = 6'b100000;
	localparam logic [5:0] FN_ADDU = 6'b100001;
	localparam logic [5:0] FN_SUB  = 6'b100010;
	localparam logic [5:0] FN_SUBU = 6'b100011;
	localparam logic [5:0] FN_AND  = 6'b100100;
	localparam logic [5:0] FN_OR   = 6'b100101;
	localparam logic [5:0] FN_XOR  = 6'b100110;
	localparam logic [5:0] FN_NOR  = 6'b100111;
	localparam logic [5:0] FN_SLT  = 6'b101010;
	localparam logic [5:0] FN_SLTU = 6'b101011;

	// REGIMM codes in the rt field
	localparam logic [4:0] RT_BLTZ   = 5'b00000;
	localparam logic [4:0] RT_BGEZ   = 5'b00001;
	localparam logic [4:0] RT_BLTZAL = 5'b10000;
	localparam logic [4:0] RT_BGEZAL = 5'b10001;

	// linking forms share the kind of their plain branch
	typedef enum logic [3:0] {
		BR_NONE,
		BR_BEQ,
		BR_BNE,
		BR_BGEZ,
		BR_BGTZ,
		BR_BLEZ,
		BR_BLTZ,
		BR_J,
		BR_JR
	} branch_kind_e;

endpackage

/* source/inst_decoder.sv */
`timescale 1ns/1ns

module inst_decoder
	import decode_pkg::*;
(
	input  word_t        inst_i,
	output logic         uses_rs_o,
	output logic         uses_rt_o,
	output logic         dest_we_o,
	output logic         legal_o,
	output reg_addr_t    dest_addr_o,
	output branch_kind_e branch_kind_o,
	output logic         is_branch_rel_o
);

	logic [5:0]   opcode;
	logic [5:0]   funct;
	logic [4:0]   shamt;
	reg_addr_t    rs;
	reg_addr_t    rt;
	reg_addr_t    rd;
	logic         legal;
	logic         use_rs;
	logic         use_rt;
	logic         wr_rt;
	logic         wr_rd;
	logic         wr_link;
	logic         rel;
	branch_kind_e kind;

	assign opcode = inst_i[31:26];
	assign rs     = inst_i[25:21];
	assign rt     = inst_i[20:16];
	assign rd     = inst_i[15:11];
	assign shamt  = inst_i[10:6];
	assign funct  = inst_i[5:0];

	////////////////////////////////////////////////////////////////////////////
	// classification
	always_comb
	begin
		legal   = 1'b0;
		use_rs  = 1'b0;
		use_rt  = 1'b0;
		wr_rt   = 1'b0;
		wr_rd   = 1'b0;
		wr_link = 1'b0;
		rel     = 1'b0;
		kind    = BR_NONE;
		case (opcode)
			OP_SPECIAL:
			begin
				case (funct)
					FN_SLL, FN_SRL, FN_SRA:
					begin
						// shift amount comes from shamt, rs must be zero
						legal  = (rs == '0);
						use_rt = 1'b1;
						wr_rd  = 1'b1;
					end
					FN_SLLV, FN_SRLV, FN_SRAV, FN_ADD, FN_ADDU, FN_SUB, FN_SUBU,
					FN_AND, FN_OR, FN_XOR, FN_NOR, FN_SLT, FN_SLTU:
					begin
						legal  = (shamt == '0);
						use_rs = 1'b1;
						use_rt = 1'b1;
						wr_rd  = 1'b1;
					end
					FN_JR:
					begin
						legal  = (inst_i[20:6] == '0);
						use_rs = 1'b1;
						kind   = BR_JR;
					end
					FN_JALR:
					begin
						legal   = (rt == '0) && (shamt == '0);
						use_rs  = 1'b1;
						wr_link = 1'b1;
						kind    = BR_JR;
					end
					default: legal = 1'b0;
				endcase
			end
			OP_REGIMM:
			begin
				legal  = 1'b1;
				use_rs = 1'b1;
				rel    = 1'b1;
				case (rt)
					RT_BLTZ: kind = BR_BLTZ;
					RT_BGEZ: kind = BR_BGEZ;
					RT_BLTZAL:
					begin
						kind    = BR_BLTZ;
						wr_link = 1'b1;
					end
					RT_BGEZAL:
					begin
						kind    = BR_BGEZ;
						wr_link = 1'b1;
					end
					default: legal = 1'b0;
				endcase
			end
			OP_J:
			begin
				legal = 1'b1;
				kind  = BR_J;
			end
			OP_JAL:
			begin
				legal   = 1'b1;
				wr_link = 1'b1;
				kind    = BR_J;
			end
			OP_BEQ, OP_BNE:
			begin
				legal  = 1'b1;
				use_rs = 1'b1;
				use_rt = 1'b1;
				rel    = 1'b1;
				kind   = (opcode == OP_BEQ) ? BR_BEQ : BR_BNE;
			end
			OP_BLEZ, OP_BGTZ:
			begin
				legal  = (rt == '0);
				use_rs = 1'b1;
				rel    = 1'b1;
				kind   = (opcode == OP_BLEZ) ? BR_BLEZ : BR_BGTZ;
			end
			OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI, OP_ORI, OP_XORI,
			OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW:
			begin
				legal  = 1'b1;
				use_rs = 1'b1;
				wr_rt  = 1'b1;
			end
			OP_LUI:
			begin
				legal = (rs == '0);
				wr_rt = 1'b1;
			end
			// partial word loads merge into the old rt value
			OP_LWL, OP_LWR:
			begin
				legal  = 1'b1;
				use_rs = 1'b1;
				use_rt = 1'b1;
				wr_rt  = 1'b1;
			end
			OP_SB, OP_SH, OP_SW, OP_SWL, OP_SWR:
			begin
				legal  = 1'b1;
				use_rs = 1'b1;
				use_rt = 1'b1;
			end
			default: legal = 1'b0;
		endcase
	end

	// an illegal word reads nothing, writes nothing and never branches
	assign legal_o         = legal;
	assign uses_rs_o       = legal & use_rs;
	assign uses_rt_o       = legal & use_rt;
	assign is_branch_rel_o = legal & rel;
	assign branch_kind_o   = legal ? kind : BR_NONE;
	assign dest_we_o       = legal & (|inst_i) & (wr_rt | wr_rd | wr_link);

	// zero when nothing is written, so the hazard check sees no producer
	assign dest_addr_o = !dest_we_o ? '0 :
		wr_link ? LINK_REG :
		wr_rt ? rt : rd;

endmodule

/* regfile/reg_file.sv */
`timescale 1ns/1ns

module reg_file
	import decode_pkg::*;
(
	input  logic      clk,
	input  logic      reset_n,
	input  reg_addr_t raddr0_i,
	input  reg_addr_t raddr1_i,
	input  reg_addr_t waddr_i,
	input  logic      we_i,
	input  word_t     wdata_i,
	output word_t     rdata0_o,
	output word_t     rdata1_o
);

	word_t regs [NUM_REGS];

	// writes are held off while reset is asserted
	always_ff @(posedge clk)
	begin
		if (reset_n && we_i && (waddr_i != '0))
			regs[waddr_i] <= wdata_i;
	end

	// r0 is hardwired, no bypass from the write port
	assign rdata0_o = (raddr0_i == '0) ? '0 : regs[raddr0_i];
	assign rdata1_o = (raddr1_i == '0) ? '0 : regs[raddr1_i];

endmodule

/* source/branch_unit.sv */
`timescale 1ns/1ns

module branch_unit
	import decode_pkg::*;
(
	input  word_t        inst_i,
	input  word_t        pc_i,
	input  word_t        rs_data_i,
	input  word_t        rt_data_i,
	input  branch_kind_e branch_kind_i,
	input  logic         is_branch_rel_i,
	input  logic         stall_i,
	output logic         branch_valid_o,
	output word_t        branch_target_o
);

	word_t seq_pc;
	word_t rel_offset;
	logic  rs_zero;
	logic  rs_neg;
	logic  taken;

	assign seq_pc     = pc_i + XLEN'(4);
	assign rel_offset = {{(XLEN-18){inst_i[15]}}, inst_i[15:0], 2'b00};
	assign rs_zero    = (rs_data_i == '0);
	assign rs_neg     = rs_data_i[XLEN-1];

	always_comb
	begin
		case (branch_kind_i)
			BR_BEQ:      taken = (rs_data_i == rt_data_i);
			BR_BNE:      taken = (rs_data_i != rt_data_i);
			BR_BGEZ:     taken = ~rs_neg;
			BR_BGTZ:     taken = ~rs_neg & ~rs_zero;
			BR_BLEZ:     taken = rs_neg | rs_zero;
			BR_BLTZ:     taken = rs_neg;
			BR_J, BR_JR: taken = 1'b1;
			default:     taken = 1'b0;
		endcase
	end

	// a stalled branch is resolved again once its operands are ready
	assign branch_valid_o = taken & ~stall_i;

	always_comb
	begin
		if (branch_kind_i == BR_NONE)
			branch_target_o = '0;
		else if (is_branch_rel_i)
			branch_target_o = seq_pc + rel_offset;
		else if (branch_kind_i == BR_J)
			branch_target_o = {pc_i[XLEN-1:XLEN-4], inst_i[25:0], 2'b00};
		else
			branch_target_o = rs_data_i;
	end

endmodule

/* source/decode_issue.sv */
`timescale 1ns/1ns

module decode_issue
	import decode_pkg::*;
(
	input  logic      clk,
	input  logic      reset_n,
	input  logic      exception_i,
	input  word_t     inst_i,
	input  word_t     pc_i,
	input  word_t     rs_data_i,
	input  word_t     rt_data_i,
	input  logic      uses_rs_i,
	input  logic      uses_rt_i,
	input  logic      dest_we_i,
	input  logic      legal_i,
	input  reg_addr_t dest_addr_i,
	input  reg_addr_t conflict_addr0_i,
	input  reg_addr_t conflict_addr1_i,
	output logic      stall_o,
	output word_t     inst_o,
	output word_t     pc_o,
	output word_t     op0_o,
	output word_t     op1_o,
	output reg_addr_t reg_waddr_o,
	output logic      reg_we_o,
	output logic      illegal_inst_o
);

	reg_addr_t rs_addr;
	reg_addr_t rt_addr;
	logic      rs_hazard;
	logic      rt_hazard;
	logic      clear;

	// r0 never carries a dependence
	function automatic logic hits(reg_addr_t src, reg_addr_t a0, reg_addr_t a1,
		reg_addr_t a2);
		return (src != '0) && ((src == a0) || (src == a1) || (src == a2));
	endfunction

	assign rs_addr = inst_i[25:21];
	assign rt_addr = inst_i[20:16];

	////////////////////////////////////////////////////////////////////////////
	// read-after-write against decode, execute and memory destinations
	assign rs_hazard = uses_rs_i &&
		hits(rs_addr, reg_waddr_o, conflict_addr0_i, conflict_addr1_i);
	assign rt_hazard = uses_rt_i &&
		hits(rt_addr, reg_waddr_o, conflict_addr0_i, conflict_addr1_i);
	assign stall_o = rs_hazard | rt_hazard;

	assign clear = !reset_n || exception_i;

	////////////////////////////////////////////////////////////////////////////
	// stage register, a stall inserts a bubble
	always_ff @(posedge clk)
	begin
		if (clear || stall_o)
		begin
			inst_o         <= '0;
			pc_o           <= '0;
			op0_o          <= '0;
			op1_o          <= '0;
			reg_waddr_o    <= '0;
			reg_we_o       <= 1'b0;
			illegal_inst_o <= 1'b0;
		end
		else
		begin
			inst_o         <= inst_i;
			pc_o           <= pc_i;
			op0_o          <= rs_data_i;
			op1_o          <= rt_data_i;
			reg_waddr_o    <= dest_addr_i;
			reg_we_o       <= dest_we_i;
			illegal_inst_o <= ~legal_i;
		end
	end

endmodule

/* source/decode_stage.sv */
`timescale 1ns/1ns

module decode_stage
	import decode_pkg::*;
(
	input  logic      clk,
	input  logic      reset_n,
	input  word_t     inst_i,
	input  word_t     pc_i,
	input  logic      reg_we_i,
	input  reg_addr_t reg_waddr_i,
	input  word_t     reg_wdata_i,
	input  reg_addr_t conflict_addr0_i,
	input  reg_addr_t conflict_addr1_i,
	input  logic      exception_i,
	output word_t     inst_o,
	output word_t     pc_o,
	output word_t     op0_o,
	output word_t     op1_o,
	output reg_addr_t reg_waddr_o,
	output logic      reg_we_o,
	output logic      illegal_inst_o,
	output logic      stall_o,
	output logic      branch_valid_o,
	output word_t     branch_target_o
);

	logic         uses_rs;
	logic         uses_rt;
	logic         dest_we;
	logic         legal;
	reg_addr_t    dest_addr;
	branch_kind_e branch_kind;
	logic         is_branch_rel;
	word_t        rs_data;
	word_t        rt_data;
	logic         stall;

	assign stall_o = stall;

	inst_decoder u_decoder (
		.inst_i          (inst_i),
		.uses_rs_o       (uses_rs),
		.uses_rt_o       (uses_rt),
		.dest_we_o       (dest_we),
		.legal_o         (legal),
		.dest_addr_o     (dest_addr),
		.branch_kind_o   (branch_kind),
		.is_branch_rel_o (is_branch_rel)
	);

	// rs on port 0, rt on port 1
	reg_file u_reg_file (
		.clk      (clk),
		.reset_n  (reset_n),
		.raddr0_i (inst_i[25:21]),
		.raddr1_i (inst_i[20:16]),
		.waddr_i  (reg_waddr_i),
		.we_i     (reg_we_i),
		.wdata_i  (reg_wdata_i),
		.rdata0_o (rs_data),
		.rdata1_o (rt_data)
	);

	branch_unit u_branch (
		.inst_i          (inst_i),
		.pc_i            (pc_i),
		.rs_data_i       (rs_data),
		.rt_data_i       (rt_data),
		.branch_kind_i   (branch_kind),
		.is_branch_rel_i (is_branch_rel),
		.stall_i         (stall),
		.branch_valid_o  (branch_valid_o),
		.branch_target_o (branch_target_o)
	);

	decode_issue u_issue (
		.clk              (clk),
		.reset_n          (reset_n),
		.exception_i      (exception_i),
		.inst_i           (inst_i),
		.pc_i             (pc_i),
		.rs_data_i        (rs_data),
		.rt_data_i        (rt_data),
		.uses_rs_i        (uses_rs),
		.uses_rt_i        (uses_rt),
		.dest_we_i        (dest_we),
		.legal_i          (legal),
		.dest_addr_i      (dest_addr),
		.conflict_addr0_i (conflict_addr0_i),
		.conflict_addr1_i (conflict_addr1_i),
		.stall_o          (stall),
		.inst_o           (inst_o),
		.pc_o             (pc_o),
		.op0_o            (op0_o),
		.op1_o            (op1_o),
		.reg_waddr_o      (reg_waddr_o),
		.reg_we_o         (reg_we_o),
		.illegal_inst_o   (illegal_inst_o)
	);

endmodule

/* sim/tb_decode_stage.sv */
`timescale 1ns/1ns

module tb_decode_stage
	import decode_pkg::*;
();

	localparam int CLK_NS      = 8;
	localparam int TEST_CYCLES = 140;
	localparam int MARGIN      = 60;
	localparam int WATCHDOG_NS = (TEST_CYCLES + MARGIN) * CLK_NS;
	localparam word_t PC_A     = 32'h0040_1000;
	localparam word_t PC_B     = 32'ha000_0040;

	logic      clk;
	logic      reset_n;
	word_t     inst_i;
	word_t     pc_i;
	logic      reg_we_i;
	reg_addr_t reg_waddr_i;
	word_t     reg_wdata_i;
	reg_addr_t conflict_addr0_i;
	reg_addr_t conflict_addr1_i;
	logic      exception_i;
	word_t     inst_o;
	word_t     pc_o;
	word_t     op0_o;
	word_t     op1_o;
	reg_addr_t reg_waddr_o;
	logic      reg_we_o;
	logic      illegal_inst_o;
	logic      stall_o;
	logic      branch_valid_o;
	word_t     branch_target_o;

	// expected register file contents
	word_t       shadow [NUM_REGS];
	int unsigned seed_word;

	decode_stage u_dut (
		.clk              (clk),
		.reset_n          (reset_n),
		.inst_i           (inst_i),
		.pc_i             (pc_i),
		.reg_we_i         (reg_we_i),
		.reg_waddr_i      (reg_waddr_i),
		.reg_wdata_i      (reg_wdata_i),
		.conflict_addr0_i (conflict_addr0_i),
		.conflict_addr1_i (conflict_addr1_i),
		.exception_i      (exception_i),
		.inst_o           (inst_o),
		.pc_o             (pc_o),
		.op0_o            (op0_o),
		.op1_o            (op1_o),
		.reg_waddr_o      (reg_waddr_o),
		.reg_we_o         (reg_we_o),
		.illegal_inst_o   (illegal_inst_o),
		.stall_o          (stall_o),
		.branch_valid_o   (branch_valid_o),
		.branch_target_o  (branch_target_o)
	);

	always #(CLK_NS/2) clk = ~clk;

	////////////////////////////////////////////////////////////////////////////
	// compare tasks
	task automatic check_word(input word_t got, input word_t exp, input string msg);
		if (got !== exp)
		begin
			$display("CHECK FAILED at %0t ns: %s got %h expected %h", $time, msg, got, exp);
			$display("SOME TESTS FAILED");
			$fatal(1, "word mismatch");
		end
	endtask

	task automatic check_addr(input reg_addr_t got, input reg_addr_t exp, input string msg);
		if (got !== exp)
		begin
			$display("CHECK FAILED at %0t ns: %s got %0d expected %0d", $time, msg, got, exp);
			$display("SOME TESTS FAILED");
			$fatal(1, "address mismatch");
		end
	endtask

	task automatic check_bit(input logic got, input logic exp, input string msg);
		if (got !== exp)
		begin
			$display("CHECK FAILED at %0t ns: %s got %b expected %b", $time, msg, got, exp);
			$display("SOME TESTS FAILED");
			$fatal(1, "bit mismatch");
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// instruction encoders and expected targets
	function automatic word_t r_type(input reg_addr_t rs, input reg_addr_t rt,
		input reg_addr_t rd, input logic [4:0] shamt, input logic [5:0] funct);
		return {OP_SPECIAL, rs, rt, rd, shamt, funct};
	endfunction

	function automatic word_t i_type(input logic [5:0] op, input reg_addr_t rs,
		input reg_addr_t rt, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic word_t rel_target(input word_t pc, input logic [15:0] off);
		return pc + 32'd4 + {{14{off[15]}}, off, 2'b00};
	endfunction

	function automatic word_t jump_target(input word_t pc, input logic [25:0] index);
		return {pc[31:28], index, 2'b00};
	endfunction

	// drive on the rising edge, look at the outputs on the falling edge
	task automatic present(input word_t inst, input word_t pc, input reg_addr_t c0,
		input reg_addr_t c1);
		@(posedge clk);
		inst_i           <= inst;
		pc_i             <= pc;
		conflict_addr0_i <= c0;
		conflict_addr1_i <= c1;
		@(negedge clk);
	endtask

	task automatic hold_cycle();
		@(posedge clk);
		@(negedge clk);
	endtask

	task automatic write_reg(input reg_addr_t addr, input word_t data);
		@(posedge clk);
		reg_we_i    <= 1'b1;
		reg_waddr_i <= addr;
		reg_wdata_i <= data;
		@(posedge clk);
		reg_we_i <= 1'b0;
		if (addr != '0)
			shadow[addr] = data;
	endtask

	task automatic decode_dest(input word_t inst, input reg_addr_t exp_addr,
		input logic exp_we, input string msg);
		present(inst, PC_A, '0, '0);
		present('0, '0, '0, '0);
		check_bit(reg_we_o, exp_we, {msg, " reg_we_o"});
		if (exp_we)
			check_addr(reg_waddr_o, exp_addr, {msg, " reg_waddr_o"});
	endtask

	task automatic branch_outcome(input word_t inst, input word_t pc, input reg_addr_t c0,
		input logic exp_valid, input word_t exp_target, input string msg);
		present(inst, pc, c0, '0);
		check_bit(branch_valid_o, exp_valid, {msg, " branch_valid_o"});
		check_word(branch_target_o, exp_target, {msg, " branch_target_o"});
	endtask

	////////////////////////////////////////////////////////////////////////////
	// directed tests
	task automatic reg_file_test();
		int i;
		for (i = 1; i < NUM_REGS; i++)
			write_reg(reg_addr_t'(i), word_t'($urandom()));
		present(r_type(5'd7, 5'd20, 5'd5, 5'd0, FN_ADD), PC_A, '0, '0);
		present('0, '0, '0, '0);
		check_word(op0_o, shadow[7], "add r7 op0_o");
		check_word(op1_o, shadow[20], "add r20 op1_o");
		present(r_type(5'd31, 5'd1, 5'd6, 5'd0, FN_ADD), PC_A, '0, '0);
		present('0, '0, '0, '0);
		check_word(op0_o, shadow[31], "add r31 op0_o");
		check_word(op1_o, shadow[1], "add r1 op1_o");
		// r0 stays zero after a write
		write_reg('0, 32'hdead_beef);
		present(r_type(5'd0, 5'd9, 5'd2, 5'd0, FN_ADD), PC_A, '0, '0);
		present('0, '0, '0, '0);
		check_word(op0_o, '0, "add r0 op0_o");
		check_word(op1_o, shadow[9], "add r9 op1_o");
	endtask

	task automatic dest_test();
		decode_dest(r_type(5'd1, 5'd2, 5'd5, 5'd0, FN_ADD), 5'd5, 1'b1, "add");
		decode_dest(i_type(OP_ADDIU, 5'd1, 5'd6, 16'h0010), 5'd6, 1'b1, "addiu");
		decode_dest(i_type(OP_LW, 5'd1, 5'd7, 16'h0004), 5'd7, 1'b1, "lw");
		decode_dest({OP_JAL, 26'h000_0100}, 5'd31, 1'b1, "jal");
		decode_dest(i_type(OP_SW, 5'd1, 5'd8, 16'h0008), '0, 1'b0, "sw");
		decode_dest(i_type(OP_BEQ, 5'd1, 5'd2, 16'h0002), '0, 1'b0, "beq");
	endtask

	task automatic hazard_test();
		word_t dep;
		dep = r_type(5'd6, 5'd7, 5'd9, 5'd0, FN_ADD);
		present(dep, PC_A, 5'd6, '0);
		check_bit(stall_o, 1'b1, "rs on conflict0 stall_o");
		hold_cycle();
		check_bit(reg_we_o, 1'b0, "bubble reg_we_o");
		check_word(inst_o, '0, "bubble inst_o");
		present(dep, PC_A, '0, 5'd7);
		check_bit(stall_o, 1'b1, "rt on conflict1 stall_o");
		present(dep, PC_A, '0, '0);
		check_bit(stall_o, 1'b0, "conflicts gone stall_o");
		present('0, '0, '0, '0);
		check_word(inst_o, dep, "issued after stall inst_o");
		// back to back on the in-flight destination
		present(r_type(5'd1, 5'd2, 5'd3, 5'd0, FN_ADD), PC_A, '0, '0);
		present(r_type(5'd3, 5'd1, 5'd4, 5'd0, FN_ADD), PC_A, '0, '0);
		check_bit(stall_o, 1'b1, "back to back stall_o");
		hold_cycle();
		check_bit(reg_we_o, 1'b0, "back to back bubble reg_we_o");
		check_bit(stall_o, 1'b0, "back to back released stall_o");
		present('0, '0, '0, '0);
		check_addr(reg_waddr_o, 5'd4, "back to back reg_waddr_o");
		present(r_type(5'd1, 5'd2, 5'd0, 5'd0, FN_ADD), PC_A, '0, '0);
		present(r_type(5'd0, 5'd0, 5'd5, 5'd0, FN_ADD), PC_A, '0, '0);
		check_bit(stall_o, 1'b0, "r0 dependence stall_o");
		// sll reads rt only
		present(r_type(5'd9, 5'd2, 5'd8, 5'd3, FN_SLL), PC_A, 5'd9, '0);
		check_bit(stall_o, 1'b0, "sll rs field stall_o");
		present(r_type(5'd0, 5'd9, 5'd8, 5'd3, FN_SLL), PC_A, 5'd9, '0);
		check_bit(stall_o, 1'b1, "sll rt stall_o");
		present('0, '0, '0, '0);
	endtask

	task automatic branch_test();
		write_reg(5'd10, 32'h8000_0010);
		write_reg(5'd12, 32'h0000_0123);
		write_reg(5'd13, 32'h0000_0123);
		branch_outcome(i_type(OP_BEQ, 5'd12, 5'd13, 16'h0010), PC_A, '0, 1'b1,
			rel_target(PC_A, 16'h0010), "beq equal");
		branch_outcome(i_type(OP_BEQ, 5'd12, 5'd10, 16'hfff0), PC_A, '0, 1'b0,
			rel_target(PC_A, 16'hfff0), "beq unequal");
		branch_outcome(i_type(OP_BNE, 5'd12, 5'd10, 16'hfff0), PC_A, '0, 1'b1,
			rel_target(PC_A, 16'hfff0), "bne unequal");
		branch_outcome(i_type(OP_BNE, 5'd12, 5'd13, 16'h0010), PC_A, '0, 1'b0,
			rel_target(PC_A, 16'h0010), "bne equal");
		// rs negative, zero, positive
		branch_outcome(i_type(OP_REGIMM, 5'd10, RT_BGEZ, 16'h0008), PC_A, '0, 1'b0,
			rel_target(PC_A, 16'h0008), "bgez neg");
		branch_outcome(i_type(OP_REGIMM, 5'd0, RT_BGEZ, 16'h0008), PC_A, '0, 1'b1,
			rel_target(PC_A, 16'h0008), "bgez zero");
		branch_outcome(i_type(OP_REGIMM, 5'd12, RT_BGEZ, 16'h0008), PC_A, '0, 1'b1,
			rel_target(PC_A, 16'h0008), "bgez pos");
		branch_outcome(i_type(OP_BGTZ, 5'd10, 5'd0, 16'h8000), PC_A, '0, 1'b0,
			rel_target(PC_A, 16'h8000), "bgtz neg");
		branch_outcome(i_type(OP_BGTZ, 5'd0, 5'd0, 16'h8000), PC_A, '0, 1'b0,
			rel_target(PC_A, 16'h8000), "bgtz zero");
		branch_outcome(i_type(OP_BGTZ, 5'd12, 5'd0, 16'h8000), PC_A, '0, 1'b1,
			rel_target(PC_A, 16'h8000), "bgtz pos");
		branch_outcome(i_type(OP_BLEZ, 5'd10, 5'd0, 16'h0020), PC_B, '0, 1'b1,
			rel_target(PC_B, 16'h0020), "blez neg");
		branch_outcome(i_type(OP_BLEZ, 5'd0, 5'd0, 16'h0020), PC_B, '0, 1'b1,
			rel_target(PC_B, 16'h0020), "blez zero");
		branch_outcome(i_type(OP_BLEZ, 5'd12, 5'd0, 16'h0020), PC_B, '0, 1'b0,
			rel_target(PC_B, 16'h0020), "blez pos");
		branch_outcome(i_type(OP_REGIMM, 5'd10, RT_BLTZ, 16'hff00), PC_B, '0, 1'b1,
			rel_target(PC_B, 16'hff00), "bltz neg");
		branch_outcome(i_type(OP_REGIMM, 5'd0, RT_BLTZ, 16'hff00), PC_B, '0, 1'b0,
			rel_target(PC_B, 16'hff00), "bltz zero");
		branch_outcome(i_type(OP_REGIMM, 5'd12, RT_BLTZ, 16'hff00), PC_B, '0, 1'b0,
			rel_target(PC_B, 16'hff00), "bltz pos");
		branch_outcome({OP_J, 26'h012_3456}, PC_B, '0, 1'b1,
			jump_target(PC_B, 26'h012_3456), "j");
		branch_outcome({OP_JAL, 26'h3ff_0001}, PC_B, '0, 1'b1,
			jump_target(PC_B, 26'h3ff_0001), "jal");
		branch_outcome(r_type(5'd12, 5'd0, 5'd0, 5'd0, FN_JR), PC_B, '0, 1'b1,
			shadow[12], "jr");
		branch_outcome(i_type(OP_BEQ, 5'd12, 5'd13, 16'h0010), PC_A, 5'd12, 1'b0,
			rel_target(PC_A, 16'h0010), "beq stalled");
		present('0, '0, '0, '0);
	endtask

	task automatic illegal_flush_test();
		word_t add_w;
		word_t bad_w;
		add_w = r_type(5'd1, 5'd2, 5'd5, 5'd0, FN_ADD);
		bad_w = i_type(6'b111111, 5'd1, 5'd2, 16'h0000);
		present(bad_w, PC_A, '0, '0);
		present('0, '0, '0, '0);
		check_bit(illegal_inst_o, 1'b1, "undefined opcode illegal_inst_o");
		decode_dest(i_type(OP_ADDIU, 5'd1, 5'd6, 16'h0001), 5'd6, 1'b1, "addiu again");
		check_bit(illegal_inst_o, 1'b0, "addiu illegal_inst_o");
		present(add_w, PC_B, '0, '0);
		@(posedge clk);
		exception_i <= 1'b1;
		@(negedge clk);
		check_word(inst_o, add_w, "before flush inst_o");
		check_word(pc_o, PC_B, "before flush pc_o");
		// the add is still at the inputs on the flushing edge
		@(posedge clk);
		inst_i <= bad_w;
		@(negedge clk);
		check_word(inst_o, '0, "flush inst_o");
		check_word(pc_o, '0, "flush pc_o");
		check_word(op0_o, '0, "flush op0_o");
		check_word(op1_o, '0, "flush op1_o");
		check_addr(reg_waddr_o, '0, "flush reg_waddr_o");
		check_bit(reg_we_o, 1'b0, "flush reg_we_o");
		// an undefined opcode under flush raises no flag
		@(posedge clk);
		exception_i <= 1'b0;
		inst_i      <= '0;
		pc_i        <= '0;
		@(negedge clk);
		check_word(inst_o, '0, "flush undefined inst_o");
		check_bit(illegal_inst_o, 1'b0, "flush illegal_inst_o");
	endtask

	////////////////////////////////////////////////////////////////////////////
	initial
	begin
		#(WATCHDOG_NS);
		$display("timeout: the tests did not finish within %0d ns", WATCHDOG_NS);
		$display("SOME TESTS FAILED");
		$fatal(1, "watchdog expired");
	end

	initial
	begin
		seed_word        = $urandom(41);
		clk              = 1'b0;
		reset_n          = 1'b0;
		inst_i           = '0;
		pc_i             = '0;
		reg_we_i         = 1'b0;
		reg_waddr_i      = '0;
		reg_wdata_i      = '0;
		conflict_addr0_i = '0;
		conflict_addr1_i = '0;
		exception_i      = 1'b0;
		shadow[0]        = '0;
		repeat (3) @(posedge clk);
		reset_n <= 1'b1;
		reg_file_test();
		dest_test();
		hazard_test();
		branch_test();
		illegal_flush_test();
		$display("ALL TESTS PASSED");
		$finish;
	end

endmodule

/* flist.f */
common/decode_pkg.sv
source/inst_decoder.sv
regfile/reg_file.sv
source/branch_unit.sv
source/decode_issue.sv
source/decode_stage.sv
sim/tb_decode_stage.sv

/* Bender.yml */
package:
  name: decode_stage

sources:
  - common/decode_pkg.sv
  - source/inst_decoder.sv
  - regfile/reg_file.sv
  - source/branch_unit.sv
  - source/decode_issue.sv
  - source/decode_stage.sv
  - target: test
    files:
      - sim/tb_decode_stage.sv
